// ==== Makefile ====
TOP = ps2_mouse_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f ps2_mouse.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee run.log
	grep -q '>>> PASS' run.log

clean:
	rm -rf obj_dir run.log

// ==== design/mouse_host_pkg.sv ====
`default_nettype none

package mouse_host_pkg;

  // Register window seen by the processor.
  typedef enum logic [1:0] {
    REG_STATUS = 2'd0,
    REG_X      = 2'd1,
    REG_Y      = 2'd2,
    REG_NONE   = 2'd3
  } reg_addr_t;

  localparam int WORD_BITS = 10; // Width of a read word.

  // Fields of the first packet byte.
  localparam int SYNC_BIT   = 3; // Always one in a valid status byte.
  localparam int X_SIGN_BIT = 4;
  localparam int Y_SIGN_BIT = 5;

endpackage

`default_nettype wire

// ==== design/mouse_packet_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module mouse_packet_regs import mouse_host_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  ps2_byte_if.sink             frame,
  input  logic                 io_cs,
  input  reg_addr_t            addr,
  input  logic                 tx_error,
  output logic [WORD_BITS-1:0] data_out,
  output logic                 rda
);

  logic                 ack_seen; // Command reply already skipped.
  logic [1:0]           pos;      // Byte position inside the packet.
  logic [7:0]           status_buf, x_buf;
  logic [7:0]           status_q, x_q, y_q;
  logic                 take;
  logic                 pkt_done;
  logic [WORD_BITS-1:0] read_word;

  assign take     = frame.valid && ack_seen && !frame.parity_err && !frame.frame_err;
  assign pkt_done = take && pos == 2'd2;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack_seen <= 1'b0;
      pos      <= '0;
    end else if (frame.valid) begin
      ack_seen <= 1'b1;
      if (ack_seen) begin
        if (!take) begin
          pos <= '0; // Bad byte drops the packet.
        end else if (pos == 2'd0) begin
          pos <= frame.data[SYNC_BIT] ? 2'd1 : 2'd0;
        end else begin
          pos <= (pos == 2'd2) ? 2'd0 : pos + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && pos == 2'd0) status_buf <= frame.data;
    if (take && pos == 2'd1) x_buf <= frame.data;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      status_q <= '0;
      x_q      <= '0;
      y_q      <= '0;
      rda      <= 1'b0;
      data_out <= '0;
    end else begin
      if (io_cs) begin
        data_out <= read_word;
      end
      if (pkt_done) begin
        status_q <= status_buf;
        x_q      <= x_buf;
        y_q      <= frame.data;
        rda      <= 1'b1; // Newer packet wins over the read.
      end else if (io_cs && addr == REG_Y) begin
        rda <= 1'b0;
      end
    end
  end

  always_comb begin
    case (addr)
      REG_STATUS: read_word = {rda, tx_error, status_q};
      REG_X:      read_word = {{(WORD_BITS - 8){status_q[X_SIGN_BIT]}}, x_q};
      REG_Y:      read_word = {{(WORD_BITS - 8){status_q[Y_SIGN_BIT]}}, y_q};
      default:    read_word = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/ps2_cmd_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_cmd_tx import ps2_proto_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  ps2_line_if.tx   line,
  ps2_byte_if.sink frame,
  output logic     ps2_clk_drive_low,
  output logic     ps2_data_drive_low,
  output logic     tx_error
);

  localparam logic ODD_PAR = ~^CMD_ENABLE;

  tx_state_t                   state;
  logic [INHIBIT_CNT_BITS-1:0] inhibit_cnt;
  logic [7:0]                  shreg;
  logic [2:0]                  bit_cnt;
  logic                        released;   // Clock line seen high after the inhibit.
  logic                        reply_seen;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state              <= TX_INHIBIT;
      inhibit_cnt        <= '0;
      shreg              <= CMD_ENABLE;
      bit_cnt            <= '0;
      released           <= 1'b0;
      reply_seen         <= 1'b0;
      ps2_clk_drive_low  <= 1'b0;
      ps2_data_drive_low <= 1'b0;
      tx_error           <= 1'b0;
      line.rx_enable     <= 1'b0;
    end else begin
      case (state)
        TX_INHIBIT: begin
          inhibit_cnt       <= inhibit_cnt + 1'b1;
          ps2_clk_drive_low <= 1'b1;
          if (inhibit_cnt == INHIBIT_CNT_BITS'(INHIBIT_CYCLES - 1)) begin
            ps2_data_drive_low <= 1'b1; // Start bit, request to send.
          end
          if (inhibit_cnt == INHIBIT_CNT_BITS'(INHIBIT_CYCLES)) begin
            ps2_clk_drive_low <= 1'b0;
            state             <= TX_START;
          end
        end
        TX_START: begin
          if (line.clk_rise) begin
            released <= 1'b1;
          end
          // Device drives the clock from here on.
          if (released && line.clk_fall) begin
            ps2_data_drive_low <= ~shreg[0];
            shreg              <= {1'b1, shreg[7:1]};
            bit_cnt            <= '0;
            state              <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (line.clk_fall) begin
            if (bit_cnt == 3'd7) begin
              ps2_data_drive_low <= ~ODD_PAR;
              state              <= TX_PARITY;
            end else begin
              ps2_data_drive_low <= ~shreg[0];
              shreg              <= {1'b1, shreg[7:1]};
              bit_cnt            <= bit_cnt + 3'd1;
            end
          end
        end
        TX_PARITY: begin
          if (line.clk_fall) begin
            ps2_data_drive_low <= 1'b0; // Stop bit is the released line.
            state              <= TX_STOP;
          end
        end
        TX_STOP: begin
          if (line.clk_fall) begin
            if (line.data_bit) begin
              tx_error <= 1'b1; // Device did not pull the ack bit low.
            end
            state <= TX_ACK;
          end
        end
        TX_ACK: begin
          if (line.clk_level && line.data_bit) begin
            line.rx_enable <= 1'b1;
            state          <= TX_DONE;
          end
        end
        TX_DONE: begin
          // First received byte answers the command.
          if (frame.valid && !reply_seen) begin
            reply_seen <= 1'b1;
            if (frame.data != ACK_BYTE || frame.parity_err || frame.frame_err) begin
              tx_error <= 1'b1;
            end
          end
        end
        default: state <= TX_INHIBIT;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/ps2_frame_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_frame_rx import ps2_proto_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  ps2_line_if.rx line,
  ps2_byte_if.rx frame
);

  rx_state_t  state;
  logic [2:0] bit_cnt;
  logic       parity;  // Running XOR of data and parity bits.
  logic [7:0] shreg;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state            <= RX_IDLE;
      bit_cnt          <= '0;
      parity           <= 1'b0;
      frame.valid      <= 1'b0;
      frame.parity_err <= 1'b0;
      frame.frame_err  <= 1'b0;
    end else begin
      frame.valid <= 1'b0;
      if (!line.rx_enable) begin
        state <= RX_IDLE;
      end else if (line.clk_fall) begin
        case (state)
          RX_IDLE: begin
            if (!line.data_bit) begin // Start bit.
              state   <= RX_DATA;
              bit_cnt <= '0;
              parity  <= 1'b0;
            end
          end
          RX_DATA: begin
            parity <= parity ^ line.data_bit;
            if (bit_cnt == 3'(FRAME_BITS - 4)) begin
              state <= RX_PARITY;
            end else begin
              bit_cnt <= bit_cnt + 3'd1;
            end
          end
          RX_PARITY: begin
            parity <= parity ^ line.data_bit;
            state  <= RX_STOP;
          end
          RX_STOP: begin
            frame.valid      <= 1'b1;
            frame.parity_err <= ~parity;         // Total must be odd.
            frame.frame_err  <= ~line.data_bit;  // Stop bit must be high.
            state            <= RX_IDLE;
          end
          default: state <= RX_IDLE;
        endcase
      end
    end
  end

  // Data bits arrive LSB first.
  always_ff @(posedge clk) begin
    if (line.clk_fall && state == RX_DATA) begin
      shreg <= {line.data_bit, shreg[7:1]};
    end
  end

  assign frame.data = shreg;

endmodule

`default_nettype wire

// ==== design/ps2_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

// Synchronized PS/2 line events and receiver enable.
interface ps2_line_if;
  logic clk_fall;
  logic clk_rise;
  logic data_bit;
  logic clk_level;
  logic rx_enable; // Low while the transmitter owns the lines.

  modport sync (output clk_fall, output clk_rise, output data_bit, output clk_level);
  modport tx (
    input  clk_fall,
    input  clk_rise,
    input  data_bit,
    input  clk_level,
    output rx_enable
  );
  modport rx (input clk_fall, input clk_rise, input data_bit, input clk_level, input rx_enable);
endinterface

// Received byte, valid for one cycle.
interface ps2_byte_if;
  logic [7:0] data;
  logic       valid;
  logic       parity_err;
  logic       frame_err;

  modport rx (output data, output valid, output parity_err, output frame_err);
  modport sink (input data, input valid, input parity_err, input frame_err);
endinterface

`default_nettype wire

// ==== design/ps2_line_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_line_sync (
  input  logic   clk,
  input  logic   rst,
  input  logic   ps2_clk,
  input  logic   ps2_data,
  ps2_line_if.sync line
);

  logic clk_s1, clk_s2, clk_q;
  logic data_s1, data_s2, data_q;

  // Both lines idle high.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_s1  <= 1'b1;
      clk_s2  <= 1'b1;
      clk_q   <= 1'b1;
      data_s1 <= 1'b1;
      data_s2 <= 1'b1;
      data_q  <= 1'b1;
    end else begin
      clk_s1  <= ps2_clk;
      clk_s2  <= clk_s1;
      clk_q   <= clk_s2; // Previous settled level.
      data_s1 <= ps2_data;
      data_s2 <= data_s1;
      data_q  <= data_s2;
    end
  end

  // Strobes are registered so they line up with data_q.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      line.clk_fall <= 1'b0;
      line.clk_rise <= 1'b0;
    end else begin
      line.clk_fall <= clk_q & ~clk_s2;
      line.clk_rise <= ~clk_q & clk_s2;
    end
  end

  assign line.data_bit  = data_q;
  assign line.clk_level = clk_q;

endmodule

`default_nettype wire

// ==== design/ps2_mouse.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_mouse import mouse_host_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ps2_clk,            // Sampled line level.
  input  logic                 ps2_data,
  input  logic                 io_cs,
  input  logic [1:0]           addr,
  output logic                 ps2_clk_drive_low,
  output logic                 ps2_data_drive_low,
  output logic [WORD_BITS-1:0] data_out,
  output logic                 rda,
  output logic                 tx_error
);

  ps2_line_if line_if ();
  ps2_byte_if byte_if ();

  ps2_line_sync u_sync (
    .clk      (clk),
    .rst      (rst),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .line     (line_if.sync)
  );

  ps2_frame_rx u_rx (
    .clk   (clk),
    .rst   (rst),
    .line  (line_if.rx),
    .frame (byte_if.rx)
  );

  ps2_cmd_tx u_tx (
    .clk                (clk),
    .rst                (rst),
    .line               (line_if.tx),
    .frame              (byte_if.sink),
    .ps2_clk_drive_low  (ps2_clk_drive_low),
    .ps2_data_drive_low (ps2_data_drive_low),
    .tx_error           (tx_error)
  );

  mouse_packet_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .frame    (byte_if.sink),
    .io_cs    (io_cs),
    .addr     (reg_addr_t'(addr)),
    .tx_error (tx_error),
    .data_out (data_out),
    .rda      (rda)
  );

endmodule

`default_nettype wire

// ==== design/ps2_proto_pkg.sv ====
`default_nettype none

package ps2_proto_pkg;

  // Device frame: start bit, eight data bits LSB first, odd parity, stop bit.
  localparam int FRAME_BITS = 11;

  // Host holds the clock line low this long before a command (100 us at 10 MHz).
  localparam int INHIBIT_CYCLES = 1000;

  localparam int INHIBIT_CNT_BITS = $clog2(INHIBIT_CYCLES + 1);

  localparam logic [7:0] CMD_ENABLE = 8'hF4; // Enable data reporting.
  localparam logic [7:0] ACK_BYTE = 8'hFA;

  // Host-to-device transfer.
  typedef enum logic [2:0] {
    TX_INHIBIT,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP,
    TX_ACK,   // Ack bit taken, waiting for the device to free the lines.
    TX_DONE
  } tx_state_t;

  // Device-to-host frame.
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

endpackage

`default_nettype wire

// ==== ps2_mouse.f ====
design/ps2_proto_pkg.sv
design/mouse_host_pkg.sv
design/ps2_ifs.sv
design/ps2_line_sync.sv
design/ps2_frame_rx.sv
design/ps2_cmd_tx.sv
design/mouse_packet_regs.sv
design/ps2_mouse.sv
tests/ps2_mouse_assertions.sv
tests/ps2_mouse_tb.sv

// ==== tests/ps2_mouse_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_mouse_assertions import ps2_proto_pkg::*, mouse_host_pkg::*; (
  input logic                 clk,
  input logic                 rst,
  input logic                 io_cs,
  input logic [1:0]           addr,
  input logic                 ps2_clk_drive_low,
  input logic                 ps2_data_drive_low,
  input logic [WORD_BITS-1:0] data_out,
  input logic                 rda,
  input logic                 tx_error
);

  int cyc;          // Clocks since reset release, saturating.
  int failures = 0;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cyc <= 0;
    end else if (cyc <= INHIBIT_CYCLES + 1) begin
      cyc <= cyc + 1;
    end
  end

  a_reset_values: assert property (@(posedge clk) (rst && $past(rst)) |->
      (!ps2_clk_drive_low && !ps2_data_drive_low && !rda && !tx_error && data_out == '0))
    else begin failures++; $error("outputs not cleared during reset"); end

  a_clk_inhibit: assert property (@(posedge clk) disable iff (rst)
      (cyc >= 1 && cyc <= INHIBIT_CYCLES) |-> ps2_clk_drive_low)
    else begin failures++; $error("clock line released before the inhibit time ended"); end

  a_clk_release: assert property (@(posedge clk) disable iff (rst)
      (cyc == INHIBIT_CYCLES + 1) |-> !ps2_clk_drive_low)
    else begin failures++; $error("clock line still held low after the inhibit time"); end

  // Start request only in the last inhibit cycle.
  a_start_request: assert property (@(posedge clk) disable iff (rst)
      (cyc >= 1 && cyc <= INHIBIT_CYCLES) |-> (ps2_data_drive_low == (cyc == INHIBIT_CYCLES)))
    else begin failures++; $error("data line start request at the wrong time"); end

  a_hold: assert property (@(posedge clk) disable iff (rst) !io_cs |=> $stable(data_out))
    else begin failures++; $error("read word changed without a read"); end

  a_none_zero: assert property (@(posedge clk) disable iff (rst)
      (io_cs && addr == REG_NONE) |=> data_out == '0)
    else begin failures++; $error("unused address did not read zero"); end

endmodule

bind ps2_mouse ps2_mouse_assertions chk (
  .clk                (clk),
  .rst                (rst),
  .io_cs              (io_cs),
  .addr               (addr),
  .ps2_clk_drive_low  (ps2_clk_drive_low),
  .ps2_data_drive_low (ps2_data_drive_low),
  .data_out           (data_out),
  .rda                (rda),
  .tx_error           (tx_error)
);

`default_nettype wire

// ==== tests/ps2_mouse_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_mouse_tb import ps2_proto_pkg::*, mouse_host_pkg::*; ();

  localparam int HALF_BIT     = 20; // Device clock half period in system clocks.
  localparam int N_PACKETS    = 4;
  localparam int FRAME_CYCLES = FRAME_BITS * 2 * HALF_BIT + HALF_BIT;
  localparam int N_FRAMES     = 2 + 3 * (N_PACKETS + 4);
  localparam int TIMEOUT      = 3 * (16 + INHIBIT_CYCLES + N_FRAMES * FRAME_CYCLES) / 2;

  logic                 clk, rst, io_cs;
  logic [1:0]           addr;
  logic                 dev_clk_low, dev_data_low; // Pulls from the mouse model.
  logic                 ps2_clk, ps2_data;
  logic                 ps2_clk_drive_low, ps2_data_drive_low, rda, tx_error;
  logic [WORD_BITS-1:0] data_out;
  logic [31:0]          lcg_state;
  int                   errors = 0;
  int                   cycles = 0;

  // A line is low when either side pulls it.
  assign ps2_clk  = !(ps2_clk_drive_low || dev_clk_low);
  assign ps2_data = !(ps2_data_drive_low || dev_data_low);

  ps2_mouse uut (
    .clk(clk), .rst(rst), .ps2_clk(ps2_clk), .ps2_data(ps2_data), .io_cs(io_cs),
    .addr(addr), .ps2_clk_drive_low(ps2_clk_drive_low),
    .ps2_data_drive_low(ps2_data_drive_low), .data_out(data_out), .rda(rda),
    .tx_error(tx_error)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the test sequence did not finish in %0d cycles", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  task automatic check_value(input string name, input logic [WORD_BITS-1:0] got,
                             input logic [WORD_BITS-1:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Device sets data while the clock is high, host samples on the fall.
  task automatic send_bit(input logic b);
    dev_data_low = ~b;
    step(HALF_BIT);
    dev_clk_low = 1'b1;
    step(HALF_BIT);
    dev_clk_low = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] d, input logic bad_parity);
    send_bit(1'b0);
    for (int i = 0; i < 8; i++) send_bit(d[i]);
    send_bit(~^d ^ bad_parity); // Odd parity unless told otherwise.
    send_bit(1'b1);
    step(HALF_BIT);
  endtask

  task automatic take_command(output logic [9:0] bits);
    while (!ps2_clk_drive_low) step(1);
    while (ps2_clk_drive_low) step(1);
    step(HALF_BIT);
    for (int i = 0; i < 10; i++) begin
      dev_clk_low = 1'b1;
      step(HALF_BIT);
      bits[i] = ps2_data; // Sampled as the clock rises.
      dev_clk_low = 1'b0;
      step(HALF_BIT);
    end
    dev_data_low = 1'b1; // Acknowledge bit.
    dev_clk_low  = 1'b1;
    step(HALF_BIT);
    dev_clk_low  = 1'b0;
    dev_data_low = 1'b0;
    step(HALF_BIT);
  endtask

  task automatic read_reg(input logic [1:0] a, output logic [WORD_BITS-1:0] w);
    io_cs = 1'b1;
    addr  = a;
    step(1);
    io_cs = 1'b0;
    w     = data_out;
  endtask

  task automatic send_packet(input logic [7:0] s, input logic [7:0] x, input logic [7:0] y,
                             input logic bad_x);
    send_frame(s, 1'b0);
    send_frame(x, bad_x);
    send_frame(y, 1'b0);
  endtask

  task automatic read_packet(input logic [7:0] s, input logic [7:0] x, input logic [7:0] y);
    logic [WORD_BITS-1:0] w;
    while (!rda) step(1);
    read_reg(REG_STATUS, w);
    check_value("data_out status", w, {1'b1, 1'b0, s});
    read_reg(REG_X, w);
    check_value("data_out x", w, {{(WORD_BITS - 8){s[X_SIGN_BIT]}}, x});
    read_reg(REG_Y, w);
    check_value("data_out y", w, {{(WORD_BITS - 8){s[Y_SIGN_BIT]}}, y});
    check_value("rda", 10'(rda), 10'd0);
  endtask

  initial begin
    logic [9:0]           cmd_bits;
    logic [WORD_BITS-1:0] w;
    logic [7:0]           s, x, y;
    rst          = 1'b1;
    io_cs        = 1'b0;
    addr         = 2'd0;
    dev_clk_low  = 1'b0;
    dev_data_low = 1'b0;
    lcg_state    = 32'h52380049;
    repeat (16) @(posedge clk);
    #10;
    rst = 1'b0;
    check_value("clk_drive data_drive rda tx_error",
                {6'd0, ps2_clk_drive_low, ps2_data_drive_low, rda, tx_error}, '0);
    check_value("data_out", data_out, '0);

    take_command(cmd_bits);
    check_value("command byte", 10'(cmd_bits[7:0]), 10'(CMD_ENABLE));
    check_value("command parity", 10'(^cmd_bits[8:0]), 10'd1);
    check_value("command stop", 10'(cmd_bits[9]), 10'd1);
    send_frame(ACK_BYTE, 1'b0);
    check_value("tx_error", 10'(tx_error), 10'd0);

    for (int p = 0; p < N_PACKETS; p++) begin
      lcg_state   = lcg_next(lcg_state);
      s           = lcg_state[31:24];
      s[SYNC_BIT] = 1'b1;
      x           = lcg_state[23:16];
      y           = lcg_state[15:8];
      send_packet(s, x, y, 1'b0);
      read_packet(s, x, y);
    end

    send_packet(8'h30, 8'h41, 8'h87, 1'b0); // No sync bit anywhere.
    check_value("rda", 10'(rda), 10'd0);
    send_packet(8'h38, 8'h41, 8'h87, 1'b0);
    read_packet(8'h38, 8'h41, 8'h87);
    send_packet(8'h18, 8'h05, 8'h62, 1'b1); // Bad parity on x.
    check_value("rda", 10'(rda), 10'd0);
    send_packet(8'h28, 8'h7F, 8'h90, 1'b0);
    read_packet(8'h28, 8'h7F, 8'h90);

    read_reg(REG_NONE, w);
    check_value("data_out none", w, '0);
    step(5);

    $display("Errors: %0d failed checks, %0d failed assertions", errors, uut.chk.failures);
    if (errors == 0 && uut.chk.failures == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
